//--- dv/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int halfPeriod  = 4,
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;  // released on the edge after the last reset cycle
    end

endmodule

//--- dv/cpuRefModel.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// byte image of one program, its preamble addresses and the model state
localparam int progBytes = 32;
localparam codeByte_t badOpcode = 8'hEE;
localparam opcode_t singleOps [7] = '{CLAC, INCAC, MV_R_AC, MV_RC_AC, ADD, SUB, NOP};
localparam opcode_t branchOps [3] = '{JUMP, JMPZ, JMPNZ};

logic [31:0] lcgState = 32'h62bab4a5;
codeByte_t   prog [progBytes];
addr_t       preAddr [4];
dataWord_t   mDmem [`MEM_DEPTH];
dataWord_t   mAc = '0;
dataWord_t   mR = '0;
dataWord_t   mRc = '0;
bit          mZero = 1'b1;
bit          mEndDone;
addr_t       expAddr [$];
dataWord_t   expData [$];

function automatic logic [15:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState[31:16];  // upper bits, the low ones repeat quickly
endfunction

function automatic void writeAc(dataWord_t value);
    mAc   = value;
    mZero = (value == '0);
endfunction

// kind 0 straight line, 1 branches, 2 loads, 3 everything and an unknown opcode at the end
task automatic buildProgram(input int kind);
    int    pos;
    int    pick;
    int    jumpAt [$];
    int    starts [$];
    int    targets [$];
    addr_t base;
    base = addr_t'(nextRand());
    for (int k = 0; k < 4; k++) begin
        preAddr[k]      = base + addr_t'(k);
        prog[4 * k]     = LDIAC;
        prog[4 * k + 1] = codeByte_t'(nextRand());
        prog[4 * k + 2] = STR;
        prog[4 * k + 3] = preAddr[k];
    end
    pos = 16;
    while (pos < progBytes - 1) begin
        starts.push_back(pos);
        pick = nextRand() % 14;
        if (pick == 11 && kind < 2) pick = 7;
        if (pick >= 12 && (kind == 0 || kind == 2)) pick = 9;
        if (pick >= 7 && pos == progBytes - 2) pick = 1;  // no room for an operand byte
        if (pick < 7) begin
            prog[pos] = singleOps[pick];
            pos++;
        end else begin
            if (pick <= 8) begin
                prog[pos]     = LDIAC;
                prog[pos + 1] = codeByte_t'(nextRand());
            end else if (pick <= 10) begin
                prog[pos]     = STR;
                prog[pos + 1] = codeByte_t'(nextRand());
            end else if (pick == 11) begin
                prog[pos]     = LDAC;
                prog[pos + 1] = preAddr[nextRand() % 4];
            end else begin
                prog[pos] = branchOps[nextRand() % 3];
                jumpAt.push_back(pos + 1);  // target filled in below
            end
            pos += 2;
        end
    end
    prog[progBytes - 1] = (kind == 3) ? badOpcode : codeByte_t'(ENDOP);
    starts.push_back(progBytes - 1);
    // forward targets only, and only onto instruction starts
    foreach (jumpAt[j]) begin
        targets.delete();
        foreach (starts[s]) begin
            if (starts[s] > jumpAt[j]) targets.push_back(starts[s]);
        end
        prog[jumpAt[j]] = codeByte_t'(targets[nextRand() % targets.size()]);
    end
endtask

task automatic runModel();
    int        pc;
    bit        running;
    opcode_t   op;
    codeByte_t arg;
    expAddr.delete();
    expData.delete();
    pc      = 0;
    running = 1'b1;
    while (running) begin
        op  = opcode_t'(prog[pc]);
        arg = prog[(pc + 1) % progBytes];
        pc++;
        case (op)
            NOP:      ;
            ENDOP: begin
                mEndDone = 1'b1;
                running  = 1'b0;
            end
            CLAC:     writeAc('0);
            INCAC:    writeAc(mAc + 16'd1);
            ADD:      writeAc(mAc + mR);
            SUB:      writeAc(mAc - mRc);
            MV_R_AC:  mR = mAc;
            MV_RC_AC: mRc = mAc;
            LDIAC: begin
                writeAc(dataWord_t'(arg));
                pc++;
            end
            LDAC: begin
                writeAc(mDmem[arg]);
                pc++;
            end
            STR: begin
                mDmem[arg] = mAc;
                expAddr.push_back(arg);
                expData.push_back(mAc);
                pc++;
            end
            JUMP:     pc = int'(arg);
            JMPZ:     pc = mZero ? int'(arg) : pc + 1;
            JMPNZ:    pc = mZero ? pc + 1 : int'(arg);
            default: begin
                mEndDone = 1'b0;  // back to idle
                running  = 1'b0;
            end
        endcase
    end
endtask

`endif

//--- dv/tbAccumCpu.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tbAccumCpu import isaPkg::*; ();

    localparam int numProgs       = 40;
    localparam int clkPeriod      = 8;
    localparam int resetCycles    = 5;

    logic      clk;
    logic      rstN;
    logic      start;
    logic      progWrEn;
    addr_t     progAddr;
    codeByte_t progData;
    logic      ready;
    logic      done;
    dataWord_t acc;
    logic      storeEn;
    addr_t     storeAddr;
    dataWord_t storeData;

    `include "cpuRefModel.svh"

    localparam int watchdogCycles = numProgs * progBytes * 6 + resetCycles;

    clockGen #(.halfPeriod(clkPeriod / 2), .resetCycles(resetCycles)) clkGen (
        .clk(clk), .rstN(rstN)
    );

    accumCpu DUT (
        .clk(clk), .rstN(rstN), .start(start), .progWrEn(progWrEn), .progAddr(progAddr),
        .progData(progData), .ready(ready), .done(done), .acc(acc),
        .storeEn(storeEn), .storeAddr(storeAddr), .storeData(storeData)
    );

    task automatic abortRun(string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic checkData(string testName, string what, dataWord_t expected,
                             dataWord_t actual);
        if (actual !== expected) begin
            $display("** Error: %s %s expected %h actual %h", testName, what, expected, actual);
            $display("Test FAILED");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic checkAddr(string testName, string what, addr_t expected, addr_t actual);
        if (actual !== expected) begin
            $display("** Error: %s %s expected %h actual %h", testName, what, expected, actual);
            $display("Test FAILED");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic checkFlag(string testName, string what, bit expected, bit actual);
        if (actual !== expected) begin
            $display("** Error: %s %s expected %b actual %b", testName, what, expected, actual);
            $display("Test FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("watchdog expired after %0d cycles without the DUT finishing", watchdogCycles);
        $display("Test FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        string testName;
        int    nStores;
        start    = 1'b0;
        progWrEn = 1'b0;
        progAddr = '0;
        progData = '0;
        do begin
            @(posedge clk);
        end while (rstN !== 1'b1);
        @(negedge clk);
        checkFlag("reset", "ready", 1'b1, ready);
        checkFlag("reset", "done", 1'b0, done);
        checkFlag("reset", "storeEn", 1'b0, storeEn);
        for (int p = 0; p < numProgs; p++) begin
            testName = $sformatf("prog%0d kind%0d", p, p % 4);
            buildProgram(p % 4);
            runModel();
            for (int b = 0; b < progBytes; b++) begin  // DUT sits in ready or done here
                @(posedge clk);
                progWrEn <= 1'b1;
                progAddr <= addr_t'(b);
                progData <= prog[b];
            end
            @(posedge clk);
            progWrEn <= 1'b0;
            start    <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            nStores = 0;
            do begin
                @(negedge clk);  // outputs settled mid cycle
                if (storeEn) begin
                    if (nStores >= expAddr.size()) begin
                        abortRun({testName, ": DUT wrote data memory more often than predicted"});
                    end
                    checkAddr(testName, "storeAddr", expAddr[nStores], storeAddr);
                    checkData(testName, "storeData", expData[nStores], storeData);
                    nStores++;
                end
            end while (!done && !ready);
            if (nStores != expAddr.size()) begin
                abortRun({testName, ": DUT finished before making all predicted stores"});
            end
            checkFlag(testName, "done", mEndDone, done);
            checkData(testName, "acc", mAc, acc);
            @(negedge clk);  // without a new start the DUT holds its end state
            checkFlag(testName, "ready", !mEndDone, ready);
        end
        $display("Test OK");
        $finish;
    end

endmodule

//--- run.sh
#!/bin/sh
# compile and run the accumulator CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f sim.f --top-module tbAccumCpu -o simAccumCpu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simAccumCpu > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
    echo "simulation exited with status $runStatus"
    exit 1
fi

if grep -qx "Test OK" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- sim.f
+incdir+source
+incdir+dv
source/isaPkg.sv
source/ctrlPkg.sv
source/syncRam.sv
source/controlUnit.sv
source/dataPath.sv
source/accumCpu.sv
dv/clockGen.sv
dv/tbAccumCpu.sv

//--- source/accumCpu.sv
`timescale 1ns/1ps

module accumCpu import isaPkg::*, ctrlPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      start,
    input  logic      progWrEn,
    input  addr_t     progAddr,
    input  codeByte_t progData,
    output logic      ready,
    output logic      done,
    output dataWord_t acc,
    output logic      storeEn,
    output addr_t     storeAddr,
    output dataWord_t storeData
);

    aluOp_t    aluOp;
    busSel_t   busSel;
    logic      acWrEn;
    logic      rWrEn;
    logic      rcWrEn;
    logic      operandWrEn;
    logic      zWrEn;
    logic      pcInc;
    logic      pcLoad;
    logic      pcClear;
    logic      dmemWrEn;
    logic      zero;
    addr_t     pc;
    addr_t     operand;
    codeByte_t imemData;
    dataWord_t dmemData;

    // every dmem write is mirrored at the top
    assign storeEn   = dmemWrEn;
    assign storeAddr = operand;
    assign storeData = acc;

    controlUnit ctrlUnit (
        .clk(clk), .rstN(rstN), .start(start), .zero(zero), .imemData(imemData),
        .aluOp(aluOp), .busSel(busSel),
        .acWrEn(acWrEn), .rWrEn(rWrEn), .rcWrEn(rcWrEn), .operandWrEn(operandWrEn),
        .zWrEn(zWrEn), .pcInc(pcInc), .pcLoad(pcLoad), .pcClear(pcClear),
        .dmemWrEn(dmemWrEn), .ready(ready), .done(done)
    );

    dataPath dPath (
        .clk(clk), .rstN(rstN), .aluOp(aluOp), .busSel(busSel),
        .acWrEn(acWrEn), .rWrEn(rWrEn), .rcWrEn(rcWrEn), .operandWrEn(operandWrEn),
        .zWrEn(zWrEn), .pcInc(pcInc), .pcLoad(pcLoad), .pcClear(pcClear),
        .imemData(imemData), .dmemData(dmemData),
        .pc(pc), .operand(operand), .acc(acc), .zero(zero)
    );

    syncRam #(.wordT(codeByte_t)) imemRam (  // host writes, cpu reads at pc
        .clk(clk), .wrEn(progWrEn), .wrAddr(progAddr), .wrData(progData),
        .rdAddr(pc), .rdData(imemData)
    );

    syncRam #(.wordT(dataWord_t)) dmemRam (
        .clk(clk), .wrEn(dmemWrEn), .wrAddr(operand), .wrData(acc),
        .rdAddr(operand), .rdData(dmemData)
    );

endmodule

//--- source/controlUnit.sv
`timescale 1ns/1ps

module controlUnit import isaPkg::*, ctrlPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      start,
    input  logic      zero,
    input  codeByte_t imemData,
    output aluOp_t    aluOp,
    output busSel_t   busSel,
    output logic      acWrEn,
    output logic      rWrEn,
    output logic      rcWrEn,
    output logic      operandWrEn,
    output logic      zWrEn,
    output logic      pcInc,
    output logic      pcLoad,
    output logic      pcClear,
    output logic      dmemWrEn,
    output logic      ready,
    output logic      done
);

    typedef enum logic [3:0] {
        idle,
        fetch,
        decode,
        operandWait,  // imem fetching the byte after the opcode
        operand,
        execute,
        memWait,      // dmem read for LDAC
        skip,         // branch not taken, step over its operand
        halt
    } state_t;

    state_t  state, nextState;
    opcode_t opcode;
    opcode_t curOp;  // opcode held for the later states

    assign opcode = opcode_t'(imemData);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= idle;
            curOp <= NOP;
        end else begin
            state <= nextState;
            if (state == decode) begin
                curOp <= opcode;
            end
        end
    end

    always_comb begin
        nextState = state;
        unique case (state)
            idle, halt: begin
                if (start) begin
                    nextState = fetch;
                end
            end
            fetch: nextState = decode;
            decode: begin
                case (opcode)
                    NOP:                nextState = fetch;
                    ENDOP:              nextState = halt;
                    CLAC, ADD, SUB, INCAC, MV_R_AC, MV_RC_AC: nextState = execute;
                    LDIAC, LDAC, STR, JUMP: nextState = operandWait;
                    JMPZ:               nextState = zero ? operandWait : skip;
                    JMPNZ:              nextState = zero ? skip : operandWait;
                    default:            nextState = idle;  // unknown opcode
                endcase
            end
            operandWait: nextState = operand;
            operand:     nextState = (curOp == LDAC) ? memWait : execute;
            memWait:     nextState = execute;
            execute:     nextState = fetch;
            skip:        nextState = fetch;
            default:     nextState = idle;
        endcase
    end

    always_comb begin
        aluOp       = aluPass;
        busSel      = busAc;
        acWrEn      = 1'b0;
        rWrEn       = 1'b0;
        rcWrEn      = 1'b0;
        operandWrEn = 1'b0;
        zWrEn       = 1'b0;
        pcInc       = 1'b0;
        pcLoad      = 1'b0;
        pcClear     = 1'b0;
        dmemWrEn    = 1'b0;
        unique case (state)
            idle, halt: pcClear = start;
            decode:     pcInc = 1'b1;
            skip:       pcInc = 1'b1;
            operand: begin
                busSel      = busImem;
                operandWrEn = 1'b1;
                pcInc       = 1'b1;
            end
            execute: begin
                case (curOp)
                    CLAC: begin
                        aluOp  = aluClr;
                        acWrEn = 1'b1;
                        zWrEn  = 1'b1;
                    end
                    LDIAC, LDAC: begin
                        busSel = (curOp == LDAC) ? busDmem : busOperand;
                        acWrEn = 1'b1;
                        zWrEn  = 1'b1;
                    end
                    ADD, SUB: begin
                        aluOp  = (curOp == ADD) ? aluAdd : aluSub;
                        busSel = (curOp == ADD) ? busR : busRc;
                        acWrEn = 1'b1;
                        zWrEn  = 1'b1;
                    end
                    INCAC: begin
                        aluOp  = aluInc;
                        acWrEn = 1'b1;
                        zWrEn  = 1'b1;
                    end
                    STR:               dmemWrEn = 1'b1;  // ac to dmem at operand
                    JUMP, JMPZ, JMPNZ: pcLoad = 1'b1;
                    MV_R_AC:           rWrEn = 1'b1;
                    MV_RC_AC:          rcWrEn = 1'b1;
                    default:           ;
                endcase
            end
            default: ;
        endcase
    end

    assign ready = (state == idle);
    assign done  = (state == halt);

endmodule

//--- source/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// widths shared by both packages and the RAM

// accumulator, R, RC and data memory words
`define DATA_WIDTH 16

// one instruction or operand byte
`define CODE_WIDTH 8

// both memories use the same address width
`define ADDR_WIDTH 8

// words in each memory, full address range
`define MEM_DEPTH 256

`endif

//--- source/ctrlPkg.sv
package ctrlPkg;

    // operation applied to ac and the bus
    typedef enum logic [2:0] {
        aluPass,  // bus straight through
        aluAdd,
        aluSub,
        aluInc,   // ac + 1, bus ignored
        aluClr
    } aluOp_t;

    // source driven onto the internal bus
    typedef enum logic [2:0] {
        busImem,     // instruction ram byte, zero extended
        busDmem,
        busOperand,  // operand register, zero extended
        busAc,
        busR,
        busRc
    } busSel_t;

endpackage

//--- source/dataPath.sv
`timescale 1ns/1ps

module dataPath import isaPkg::*, ctrlPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  aluOp_t    aluOp,
    input  busSel_t   busSel,
    input  logic      acWrEn,
    input  logic      rWrEn,
    input  logic      rcWrEn,
    input  logic      operandWrEn,
    input  logic      zWrEn,
    input  logic      pcInc,
    input  logic      pcLoad,
    input  logic      pcClear,
    input  codeByte_t imemData,
    input  dataWord_t dmemData,
    output addr_t     pc,
    output addr_t     operand,
    output dataWord_t acc,
    output logic      zero
);

    dataWord_t rReg;
    dataWord_t rcReg;
    dataWord_t bus;
    dataWord_t aluResult;

    always_comb begin
        unique case (busSel)
            busImem:    bus = dataWord_t'(imemData);  // zero extend
            busDmem:    bus = dmemData;
            busOperand: bus = dataWord_t'(operand);
            busAc:      bus = acc;
            busR:       bus = rReg;
            busRc:      bus = rcReg;
            default:    bus = '0;
        endcase
    end

    always_comb begin
        unique case (aluOp)
            aluPass: aluResult = bus;
            aluAdd:  aluResult = acc + bus;
            aluSub:  aluResult = acc - bus;
            aluInc:  aluResult = acc + dataWord_t'(1);
            aluClr:  aluResult = '0;
            default: aluResult = bus;
        endcase
    end

    // clear wins over load, load over increment
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (pcClear) begin
            pc <= '0;
        end else if (pcLoad) begin
            pc <= operand;
        end else if (pcInc) begin
            pc <= pc + addr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (operandWrEn) begin
            operand <= addr_t'(bus);  // low byte of the bus
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            acc   <= '0;
            rReg  <= '0;
            rcReg <= '0;
            zero  <= 1'b1;  // matches ac after reset
        end else begin
            if (acWrEn) begin
                acc <= aluResult;
            end
            if (rWrEn) begin
                rReg <= bus;
            end
            if (rcWrEn) begin
                rcReg <= bus;
            end
            if (zWrEn) begin
                zero <= (aluResult == '0);
            end
        end
    end

endmodule

//--- source/isaPkg.sv
`include "cpu_consts.svh"

package isaPkg;

    typedef logic [`CODE_WIDTH-1:0] codeByte_t;  // program byte
    typedef logic [`DATA_WIDTH-1:0] dataWord_t;  // data value
    typedef logic [`ADDR_WIDTH-1:0] addr_t;      // imem or dmem address

    typedef enum logic [`CODE_WIDTH-1:0] {
        NOP      = 8'h00,
        ENDOP    = 8'h01,
        CLAC     = 8'h02,
        LDIAC    = 8'h03,  // two bytes, immediate follows
        LDAC     = 8'h04,  // two bytes, address follows
        STR      = 8'h05,  // two bytes, address follows
        JUMP     = 8'h07,
        JMPNZ    = 8'h08,
        JMPZ     = 8'h09,
        ADD      = 8'h0B,  // ac + r
        SUB      = 8'h0C,  // ac - rc
        INCAC    = 8'h0D,
        MV_RC_AC = 8'h4F,  // rc <= ac
        MV_R_AC  = 8'h5F   // r <= ac
    } opcode_t;

endpackage

//--- source/syncRam.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module syncRam #(
    parameter type wordT = logic [`DATA_WIDTH-1:0]
) (
    input  logic                   clk,
    input  logic                   wrEn,
    input  logic [`ADDR_WIDTH-1:0] wrAddr,
    input  wordT                   wrData,
    input  logic [`ADDR_WIDTH-1:0] rdAddr,
    output wordT                   rdData
);

    wordT mem [`MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
        rdData <= mem[rdAddr];  // read-before-write on a same address hit
    end

endmodule
